/* cache_sys.f */
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
common/mem_bus_if.sv
icache/icache.sv
dcache/dcache.sv
hw/block_mem.sv
hw/cache_top.sv
bench/tb_clock.sv
bench/cache_tb.sv

/* Bender.yml */
package:
  name: cache_sys

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - common/mem_pkg.sv
      - common/mem_bus_if.sv
      - icache/icache.sv
      - dcache/dcache.sv
      - hw/block_mem.sv
      - hw/cache_top.sv
      - target: test
        files:
          - bench/tb_clock.sv
          - bench/cache_tb.sv

/* bench/cache_tb.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tb;

    localparam int TIMEOUT_CYCLES = 3000;
    // index 0, index 1 and index 2, the last with tags 4 and 5.
    localparam logic [`WORD_SIZE-1:0] COLD_ADDR = 16'h0100;
    localparam logic [`WORD_SIZE-1:0] LINE_BASE = 16'h0044;
    localparam logic [`WORD_SIZE-1:0] ADDR_A    = 16'h0088;
    localparam logic [`WORD_SIZE-1:0] ADDR_B    = 16'h00a8;

    logic                  Clk;
    logic                  arst_n;
    logic [`WORD_SIZE-1:0] i_inst_addr;
    logic                  i_inst_rd;
    logic [`WORD_SIZE-1:0] o_inst;
    logic                  o_inst_busy;
    logic [`WORD_SIZE-1:0] i_data_addr;
    logic                  i_data_rd;
    logic                  i_data_wr;
    logic [`WORD_SIZE-1:0] i_data_wdata;
    logic [`WORD_SIZE-1:0] o_data_rdata;
    logic                  o_data_busy;
    logic                  i_bg;

    // memory as the cpu sees it.
    logic [`WORD_SIZE-1:0] model [`MEM_WORDS];
    logic [31:0]           lfsr;
    int                    cycles = 0;

    tb_clock u_clock (
        .o_clk    (Clk),
        .o_arst_n (arst_n)
    );

    cache_top UUT (
        .Clk          (Clk),
        .i_arst_n     (arst_n),
        .i_inst_addr  (i_inst_addr),
        .i_inst_rd    (i_inst_rd),
        .o_inst       (o_inst),
        .o_inst_busy  (o_inst_busy),
        .i_data_addr  (i_data_addr),
        .i_data_rd    (i_data_rd),
        .i_data_wr    (i_data_wr),
        .i_data_wdata (i_data_wdata),
        .o_data_rdata (o_data_rdata),
        .o_data_busy  (o_data_busy),
        .i_bg         (i_bg)
    );

    always @(posedge Clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    task automatic compare(input string name, input logic [`WORD_SIZE-1:0] expected,
                           input logic [`WORD_SIZE-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    task automatic random_word(output logic [`WORD_SIZE-1:0] w);
        for (int b = 0; b < `WORD_SIZE; b++) begin
            lfsr = lfsr_next(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    // starts on a falling edge, ends on the falling edge after completion.
    task automatic cpu_access(input logic wr, input logic [`WORD_SIZE-1:0] addr,
                              input logic [`WORD_SIZE-1:0] wdata, input logic exp_busy,
                              output logic [`WORD_SIZE-1:0] rdata);
        i_data_addr  = addr;
        i_data_wdata = wdata;
        i_data_wr    = wr;
        i_data_rd    = !wr;
        #1;
        compare("o_data_busy", exp_busy, o_data_busy);
        while (o_data_busy) begin
            @(negedge Clk);
            #1;
        end
        rdata = o_data_rdata;
        @(negedge Clk);
        i_data_rd = 1'b0;
        i_data_wr = 1'b0;
        if (wr) begin
            model[addr % `MEM_WORDS] = wdata;
        end
    endtask

    task automatic store_word(input logic [`WORD_SIZE-1:0] addr, input logic exp_busy);
        logic [`WORD_SIZE-1:0] w;
        logic [`WORD_SIZE-1:0] rd;
        random_word(w);
        cpu_access(1'b1, addr, w, exp_busy, rd);
    endtask

    task automatic load_word(input logic [`WORD_SIZE-1:0] addr, input logic exp_busy);
        logic [`WORD_SIZE-1:0] rd;
        cpu_access(1'b0, addr, '0, exp_busy, rd);
        compare("o_data_rdata", model[addr % `MEM_WORDS], rd);
    endtask

    task automatic fetch_word(input logic [`WORD_SIZE-1:0] addr, input logic exp_busy);
        i_inst_addr = addr;
        i_inst_rd   = 1'b1;
        #1;
        compare("o_inst_busy", exp_busy, o_inst_busy);
        while (o_inst_busy) begin
            @(negedge Clk);
            #1;
        end
        compare("o_inst", model[addr % `MEM_WORDS], o_inst);
        @(negedge Clk);
        i_inst_rd = 1'b0;
    endtask

    // both ports miss together, optionally held off by the bus grant.
    task automatic fetch_and_load(input logic [`WORD_SIZE-1:0] iaddr,
                                  input logic [`WORD_SIZE-1:0] daddr, input int bg_cycles);
        i_bg        = (bg_cycles > 0);
        i_inst_addr = iaddr;
        i_inst_rd   = 1'b1;
        i_data_addr = daddr;
        i_data_rd   = 1'b1;
        #1;
        compare("o_inst_busy", 1'b1, o_inst_busy);
        compare("o_data_busy", 1'b1, o_data_busy);
        for (int c = 1; c < bg_cycles; c++) begin
            @(negedge Clk);
            #1;
            compare("o_inst_busy", 1'b1, o_inst_busy);
            compare("o_data_busy", 1'b1, o_data_busy);
        end
        @(negedge Clk);
        i_bg = 1'b0;
        #1;
        while (o_inst_busy || o_data_busy) begin
            @(negedge Clk);
            #1;
        end
        compare("o_inst", model[iaddr % `MEM_WORDS], o_inst);
        compare("o_data_rdata", model[daddr % `MEM_WORDS], o_data_rdata);
        @(negedge Clk);
        i_inst_rd = 1'b0;
        i_data_rd = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // tests
    task automatic reset_idle();
        logic [`WORD_SIZE-1:0] rd;
        #1;
        compare("o_inst_busy", 1'b0, o_inst_busy);
        compare("o_data_busy", 1'b0, o_data_busy);
        @(negedge Clk);
        // unwritten memory, so only busy matters here.
        cpu_access(1'b0, COLD_ADDR, '0, 1'b1, rd);
    endtask

    task automatic write_allocate();
        for (int i = 0; i < `LINE_SIZE; i++) begin
            store_word(LINE_BASE + 16'(i), i == 0);
        end
        for (int i = 0; i < `LINE_SIZE; i++) begin
            load_word(LINE_BASE + 16'(i), 1'b0);
        end
    endtask

    task automatic dirty_eviction();
        store_word(ADDR_A, 1'b1);
        store_word(ADDR_B, 1'b1);
        load_word(ADDR_A, 1'b1);
    endtask

    task automatic memory_coherence();
        fetch_word(ADDR_A, 1'b1);
        fetch_word(ADDR_A, 1'b0);
    endtask

    task automatic bus_grant_hold();
        fetch_and_load(ADDR_B, ADDR_B, 20);
    endtask

    task automatic parallel_ports();
        // makes the data line at index 2 dirty again.
        store_word(ADDR_B, 1'b0);
        fetch_and_load(ADDR_A, ADDR_A, 0);
        fetch_word(ADDR_B, 1'b1);
    endtask

    initial begin
        i_inst_addr  = '0;
        i_inst_rd    = 1'b0;
        i_data_addr  = '0;
        i_data_rd    = 1'b0;
        i_data_wr    = 1'b0;
        i_data_wdata = '0;
        i_bg         = 1'b0;
        lfsr         = 32'hdf2d2211;
        wait (arst_n);
        @(negedge Clk);
        reset_idle();
        write_allocate();
        dirty_eviction();
        memory_coherence();
        bus_grant_hold();
        parallel_ports();
        $display("all tests passed");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

    // released on a falling edge, away from the rising edge.
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_top (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic [`WORD_SIZE-1:0] i_inst_addr,
    input  logic                  i_inst_rd,
    output logic [`WORD_SIZE-1:0] o_inst,
    output logic                  o_inst_busy,
    input  logic [`WORD_SIZE-1:0] i_data_addr,
    input  logic                  i_data_rd,
    input  logic                  i_data_wr,
    input  logic [`WORD_SIZE-1:0] i_data_wdata,
    output logic [`WORD_SIZE-1:0] o_data_rdata,
    output logic                  o_data_busy,
    input  logic                  i_bg
);

    mem_bus_if imem_bus ();
    mem_bus_if dmem_bus ();

    icache u_icache (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_addr   (i_inst_addr),
        .i_rd     (i_inst_rd),
        .o_inst   (o_inst),
        .o_busy   (o_inst_busy),
        .i_bg     (i_bg),
        .mem      (imem_bus.cache)
    );

    dcache u_dcache (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .i_addr   (i_data_addr),
        .i_rd     (i_data_rd),
        .i_wr     (i_data_wr),
        .i_wdata  (i_data_wdata),
        .o_rdata  (o_data_rdata),
        .o_busy   (o_data_busy),
        .i_bg     (i_bg),
        .mem      (dmem_bus.cache)
    );

    // port 0 serves fetches, port 1 data.
    block_mem u_mem (
        .Clk      (Clk),
        .i_arst_n (i_arst_n),
        .p0       (imem_bus.mem),
        .p1       (dmem_bus.mem)
    );

endmodule

/* hw/block_mem.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module block_mem (
    input  logic   Clk,
    input  logic   i_arst_n,
    mem_bus_if.mem p0,
    mem_bus_if.mem p1
);

    localparam int PORTS = 2;
    localparam int AW    = $clog2(`MEM_WORDS);
    localparam int CW    = $clog2(`MEM_LATENCY + 1);
    localparam int OW    = $clog2(`LINE_SIZE);

    logic [`WORD_SIZE-1:0] words [`MEM_WORDS];
    mem_pkg::mem_cmd_e     cmd [PORTS];
    logic [`WORD_SIZE-1:0] addr [PORTS];
    mem_pkg::line_t        wline [PORTS];
    mem_pkg::line_t        rline [PORTS];
    logic [CW-1:0]         cnt [PORTS];
    logic [PORTS-1:0]      busy;
    logic [PORTS-1:0]      finish;

    // wraps above the memory depth.
    function automatic logic [AW-1:0] word_addr(
        input logic [`WORD_SIZE-1:0] base,
        input int                    w
    );
        return AW'(base) + AW'(w);
    endfunction

    assign cmd[0]   = p0.cmd;
    assign addr[0]  = p0.addr;
    assign wline[0] = p0.wline;
    assign p0.rline = rline[0];
    assign p0.busy  = busy[0];

    assign cmd[1]   = p1.cmd;
    assign addr[1]  = p1.addr;
    assign wline[1] = p1.wline;
    assign p1.rline = rline[1];
    assign p1.busy  = busy[1];

    // ~~~~~~~~~~~~~~~~~~~~
    // per port latency counters.
    for (genvar g = 0; g < PORTS; g++) begin : g_port
        assign finish[g] = busy[g] && (cnt[g] == '0);

        a_aligned: assert property (@(posedge Clk) disable iff (!i_arst_n)
            (cmd[g] != mem_pkg::MEM_IDLE) |-> (addr[g][OW-1:0] == '0));
    end

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy <= '0;
            for (int p = 0; p < PORTS; p++) begin
                cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < PORTS; p++) begin
                if (finish[p]) begin
                    busy[p] <= 1'b0;
                end else if (busy[p]) begin
                    cnt[p] <= cnt[p] - 1'b1;
                end else if (cmd[p] != mem_pkg::MEM_IDLE) begin
                    busy[p] <= 1'b1;
                    cnt[p]  <= CW'(`MEM_LATENCY - 1);
                end
            end
        end
    end

    // line transfer on the last busy cycle.
    always_ff @(posedge Clk) begin
        for (int p = 0; p < PORTS; p++) begin
            if (finish[p]) begin
                for (int w = 0; w < `LINE_SIZE; w++) begin
                    if (cmd[p] == mem_pkg::MEM_WRITE) begin
                        words[word_addr(addr[p], w)]
                            <= wline[p][(`LINE_SIZE-1-w)*`WORD_SIZE +: `WORD_SIZE];
                    end else begin
                        rline[p][(`LINE_SIZE-1-w)*`WORD_SIZE +: `WORD_SIZE]
                            <= words[word_addr(addr[p], w)];
                    end
                end
            end
        end
    end

endmodule

/* dcache/dcache.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module dcache (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic [`WORD_SIZE-1:0] i_addr,
    input  logic                  i_rd,
    input  logic                  i_wr,
    input  logic [`WORD_SIZE-1:0] i_wdata,
    output logic [`WORD_SIZE-1:0] o_rdata,
    output logic                  o_busy,
    input  logic                  i_bg,
    mem_bus_if.cache              mem
);

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_WRITEBACK,
        S_REFILL
    } dstate_e;

    dstate_e                state;
    cache_pkg::cache_addr_u req_a;
    cache_pkg::cache_addr_u line_a;
    cache_pkg::cache_addr_u victim_a;
    cache_pkg::line_state_t state_q [`LINE_NUMBER];
    cache_pkg::line_state_t cur;
    mem_pkg::line_t         lines [`LINE_NUMBER];
    logic                   req;
    logic                   hit;
    logic                   dirty_victim;
    logic                   wr_hit;
    logic                   mem_done;

    // ~~~~~~~~~~~~~~~~~~~~
    // lookup
    assign req_a.raw  = i_addr;
    assign line_a.f   = '{tag: req_a.f.tag, index: req_a.f.index, offset: '0};
    assign cur        = state_q[req_a.f.index];
    // victim goes back to its own tag's line.
    assign victim_a.f = '{tag: cur.tag, index: req_a.f.index, offset: '0};

    assign req          = i_rd || i_wr;
    assign hit          = (state == S_LOOKUP) && cur.valid && (cur.tag == req_a.f.tag);
    assign dirty_victim = cur.valid && cur.dirty;
    assign wr_hit       = i_wr && hit;
    assign mem_done     = (state != S_LOOKUP) && !mem.busy;

    assign o_busy  = req && !hit;
    assign o_rdata = lines[req_a.f.index][(`LINE_SIZE-1-req_a.f.offset)*`WORD_SIZE +: `WORD_SIZE];

    // ~~~~~~~~~~~~~~~~~~~~
    // memory requests
    // cmd drops to idle in the cycle busy falls.
    always_comb begin
        mem.cmd   = mem_pkg::MEM_IDLE;
        mem.addr  = line_a.raw;
        mem.wline = lines[req_a.f.index];
        case (state)
            S_LOOKUP: begin
                if (req && !hit && !i_bg) begin
                    if (dirty_victim) begin
                        mem.cmd  = mem_pkg::MEM_WRITE;
                        mem.addr = victim_a.raw;
                    end else begin
                        mem.cmd = mem_pkg::MEM_READ;
                    end
                end
            end
            S_WRITEBACK: begin
                mem.addr = victim_a.raw;
                if (mem.busy) begin
                    mem.cmd = mem_pkg::MEM_WRITE;
                end
            end
            default: begin
                if (mem.busy) begin
                    mem.cmd = mem_pkg::MEM_READ;
                end
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // controller
    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= S_LOOKUP;
            for (int i = 0; i < `LINE_NUMBER; i++) begin
                state_q[i] <= '0;
            end
        end else begin
            case (state)
                S_LOOKUP: begin
                    if (wr_hit) begin
                        state_q[req_a.f.index].dirty <= 1'b1;
                    end else if (req && !hit && !i_bg) begin
                        state <= dirty_victim ? S_WRITEBACK : S_REFILL;
                    end
                end
                S_WRITEBACK: begin
                    // line is clean now, lookup then issues the refill.
                    if (mem_done) begin
                        state_q[req_a.f.index].dirty <= 1'b0;
                        state                        <= S_LOOKUP;
                    end
                end
                default: begin
                    if (mem_done) begin
                        state_q[req_a.f.index] <= '{valid: 1'b1, dirty: 1'b0, tag: req_a.f.tag};
                        state                  <= S_LOOKUP;
                    end
                end
            endcase
        end
    end

    // line data.
    always_ff @(posedge Clk) begin
        if (state == S_REFILL && mem_done) begin
            lines[req_a.f.index] <= mem.rline;
        end else if (wr_hit) begin
            lines[req_a.f.index][(`LINE_SIZE-1-req_a.f.offset)*`WORD_SIZE +: `WORD_SIZE]
                <= i_wdata;
        end
    end

    a_rd_wr_excl: assert property (@(posedge Clk) disable iff (!i_arst_n)
        !(i_rd && i_wr));

    // memory relies on cmd and addr being held for the whole transfer.
    a_cmd_stable: assert property (@(posedge Clk) disable iff (!i_arst_n)
        mem.busy |-> $stable(mem.cmd) && $stable(mem.addr));

endmodule

/* icache/icache.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

module icache (
    input  logic                  Clk,
    input  logic                  i_arst_n,
    input  logic [`WORD_SIZE-1:0] i_addr,
    input  logic                  i_rd,
    output logic [`WORD_SIZE-1:0] o_inst,
    output logic                  o_busy,
    input  logic                  i_bg,
    mem_bus_if.cache              mem
);

    cache_pkg::cache_addr_u req_a;
    cache_pkg::cache_addr_u line_a;
    cache_pkg::line_state_t state_q [`LINE_NUMBER];
    cache_pkg::line_state_t cur;
    mem_pkg::line_t         lines [`LINE_NUMBER];
    logic                   hit;
    logic                   refilling;
    logic                   start;

    // ~~~~~~~~~~~~~~~~~~~~
    // lookup
    assign req_a.raw = i_addr;
    assign line_a.f  = '{tag: req_a.f.tag, index: req_a.f.index, offset: '0};

    assign cur    = state_q[req_a.f.index];
    assign hit    = cur.valid && (cur.tag == req_a.f.tag);
    assign o_busy = i_rd && !hit;
    assign o_inst = lines[req_a.f.index][(`LINE_SIZE-1-req_a.f.offset)*`WORD_SIZE +: `WORD_SIZE];

    // ~~~~~~~~~~~~~~~~~~~~
    // refill
    assign start     = i_rd && !hit && !refilling && !i_bg;
    assign mem.cmd   = (start || (refilling && mem.busy)) ? mem_pkg::MEM_READ
                                                         : mem_pkg::MEM_IDLE;
    assign mem.addr  = line_a.raw;
    // read only.
    assign mem.wline = '0;

    always_ff @(posedge Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            refilling <= 1'b0;
            for (int i = 0; i < `LINE_NUMBER; i++) begin
                state_q[i] <= '0;
            end
        end else if (refilling) begin
            if (!mem.busy) begin
                refilling <= 1'b0;
                state_q[req_a.f.index] <= '{valid: 1'b1, dirty: 1'b0, tag: req_a.f.tag};
            end
        end else if (start) begin
            refilling <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (refilling && !mem.busy) begin
            lines[req_a.f.index] <= mem.rline;
        end
    end

    a_no_write: assert property (@(posedge Clk) disable iff (!i_arst_n)
        mem.cmd != mem_pkg::MEM_WRITE);

endmodule

/* common/mem_bus_if.sv */
`timescale 1ns/1ns
`include "cache_defines.svh"

interface mem_bus_if;

    mem_pkg::mem_cmd_e     cmd;
    logic [`WORD_SIZE-1:0] addr;
    mem_pkg::line_t        wline;
    mem_pkg::line_t        rline;
    logic                  busy;

    // cmd and addr are held until busy falls.
    modport cache (
        output cmd,
        output addr,
        output wline,
        input  rline,
        input  busy
    );

    modport mem (
        input  cmd,
        input  addr,
        input  wline,
        output rline,
        output busy
    );

endinterface

/* common/mem_pkg.sv */
`include "cache_defines.svh"

package mem_pkg;

    // word 0 sits in the top bits.
    typedef logic [`LINE_SIZE*`WORD_SIZE-1:0] line_t;

    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_cmd_e;

endpackage

/* common/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

    // cpu word address split for lookup.
    typedef struct packed {
        logic [`TAG_SIZE-1:0]             tag;
        logic [$clog2(`LINE_NUMBER)-1:0] index;
        logic [$clog2(`LINE_SIZE)-1:0]   offset;
    } addr_fields_t;

    // whole address for memory, fields for the tag array.
    typedef union packed {
        logic [`WORD_SIZE-1:0] raw;
        addr_fields_t          f;
    } cache_addr_u;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`TAG_SIZE-1:0] tag;
    } line_state_t;

endpackage

/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cpu word and cache geometry.
`define WORD_SIZE 16
`define LINE_NUMBER 8
`define LINE_SIZE 4
`define TAG_SIZE 11

// backing memory.
`define MEM_WORDS 1024
`define MEM_LATENCY 4

`endif
